// File: rc_consts.svh
`ifndef RC_CONSTS_SVH
`define RC_CONSTS_SVH

// Byte and FIFO word widths
`define RC_DATA_W 8
`define RC_WORD_W 16

// FIFO depth in 16-bit words
`define RC_FIFO_WORDS 2048

// Byte count needs one bit more than the word count
`define RC_WR_CNT_W 13
`define RC_RD_CNT_W 12

// Bit period in clocks and operand timeout in bit periods
`define RC_TIMER_W 10

`define RC_CMD_W 8

`endif

// File: rc_control.sv
`timescale 1ns/1ps
`include "rc_consts.svh"

module rc_control (
	input  logic                   clock,
	input  logic                   rst_n,
	input  logic                   want_at,
	input  logic [`RC_TIMER_W-1:0] timer_cap,
	input  logic [`RC_TIMER_W-1:0] cpd,
	rx_byte_if.ctrl                rxb,
	output logic                   wr_en,
	output logic [`RC_DATA_W-1:0]  wr_data,
	output logic                   at_response_flag,
	output logic [`RC_DATA_W-1:0]  stream_select,
	output logic                   ds_sending_flag
);

	rc_pkg::rc_state_t      state;
	rc_pkg::rc_cmd_t        cmd_q;
	logic                   seen_o;
	logic                   good_byte;
	logic [`RC_TIMER_W-1:0] cyc_cnt;
	logic [`RC_TIMER_W-1:0] bit_cnt;

	assign good_byte = rxb.valid && !rxb.frame_err;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state            <= rc_pkg::RC_IDLE;
			seen_o           <= 1'b0;
			cyc_cnt          <= '0;
			bit_cnt          <= '0;
			wr_en            <= 1'b0;
			at_response_flag <= 1'b0;
			stream_select    <= '0;
			ds_sending_flag  <= 1'b0;
		end else begin
			wr_en <= 1'b0;
			if (!want_at)
				at_response_flag <= 1'b0;

			// A mode change wins over any byte and drops a held command
			if (want_at && state != rc_pkg::RC_AT) begin
				state  <= rc_pkg::RC_AT;
				seen_o <= 1'b0;
			end else if (!want_at && state == rc_pkg::RC_AT) begin
				state <= rc_pkg::RC_IDLE;
			end else begin
				case (state)
					rc_pkg::RC_AT: begin
						if (good_byte) begin
							wr_en  <= 1'b1;
							seen_o <= (rxb.data == "O");
							if (seen_o && rxb.data == "K")
								at_response_flag <= 1'b1;
						end
					end
					rc_pkg::RC_IDLE: begin
						cyc_cnt <= '0;
						bit_cnt <= '0;
						if (good_byte) begin
							case (rxb.data)
								rc_pkg::CMD_STREAM_SEL,
								rc_pkg::CMD_SEND_FLAG: state <= rc_pkg::RC_OPERAND;
								rc_pkg::CMD_NOP:       state <= rc_pkg::RC_IDLE;
								default:               state <= rc_pkg::RC_IDLE;
							endcase
						end
					end
					rc_pkg::RC_OPERAND: begin
						if (good_byte) begin
							state <= rc_pkg::RC_IDLE;
							case (cmd_q)
								rc_pkg::CMD_STREAM_SEL: stream_select   <= rxb.data;
								rc_pkg::CMD_SEND_FLAG:  ds_sending_flag <= rxb.data[0];
								default:                state           <= rc_pkg::RC_IDLE;
							endcase
						end else if (bit_cnt == timer_cap) begin
							// An operand frame already on the line is allowed to finish
							if (!rxb.busy)
								state <= rc_pkg::RC_IDLE;
						end else if (cyc_cnt == cpd - 1'b1) begin
							cyc_cnt <= '0;
							bit_cnt <= bit_cnt + 1'b1;
						end else begin
							cyc_cnt <= cyc_cnt + 1'b1;
						end
					end
					default: state <= rc_pkg::RC_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge clock) begin
		if (good_byte) begin
			wr_data <= rxb.data;
			if (state == rc_pkg::RC_IDLE)
				cmd_q <= rc_pkg::rc_cmd_t'(rxb.data);
		end
	end

endmodule

// File: rc_pkg.sv
`include "rc_consts.svh"

package rc_pkg;

	// Parser state of the control block
	typedef enum logic [1:0] {
		RC_IDLE,
		RC_OPERAND,
		RC_AT
	} rc_state_t;

	// Command codes seen on the serial line in command mode
	typedef enum logic [`RC_CMD_W-1:0] {
		CMD_NOP        = 8'h00,
		CMD_STREAM_SEL = 8'h78,
		CMD_SEND_FLAG  = 8'h79
	} rc_cmd_t;

endpackage

// File: receiver_centre.f
+incdir+.
rc_pkg.sv
rx_byte_if.sv
uart_rx.sv
rx_fifo.sv
rc_control.sv
receiver_centre.sv
tb_uart_tx.sv
tb_receiver_centre.sv

// File: receiver_centre.sv
`timescale 1ns/1ps
`include "rc_consts.svh"

module receiver_centre (
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic [`RC_TIMER_W-1:0]  uart_cpd,
	input  logic [`RC_TIMER_W-1:0]  uart_timer_cap,
	input  logic                    fpga_rxd,
	input  logic                    want_at,
	output logic                    at_response_flag,
	input  logic                    RFIFO_rd_en,
	output logic [`RC_WORD_W-1:0]   RFIFO_out,
	output logic [`RC_WR_CNT_W-1:0] RFIFO_wr_count,
	output logic [`RC_RD_CNT_W-1:0] RFIFO_rd_count,
	output logic [`RC_DATA_W-1:0]   stream_select,
	output logic                    ds_sending_flag
);

	logic                  fifo_wr_en;
	logic [`RC_DATA_W-1:0] fifo_wr_data;

	rx_byte_if rxb_bus ();

	uart_rx u_uart_rx (
		.clock (clock),
		.rst_n (rst_n),
		.cpd   (uart_cpd),
		.rxd   (fpga_rxd),
		.rxb   (rxb_bus.rx)
	);

	rc_control u_rc_control (
		.clock            (clock),
		.rst_n            (rst_n),
		.want_at          (want_at),
		.timer_cap        (uart_timer_cap),
		.cpd              (uart_cpd),
		.rxb              (rxb_bus.ctrl),
		.wr_en            (fifo_wr_en),
		.wr_data          (fifo_wr_data),
		.at_response_flag (at_response_flag),
		.stream_select    (stream_select),
		.ds_sending_flag  (ds_sending_flag)
	);

	rx_fifo u_rx_fifo (
		.clock    (clock),
		.rst_n    (rst_n),
		.wr_en    (fifo_wr_en),
		.wr_data  (fifo_wr_data),
		.rd_en    (RFIFO_rd_en),
		.rd_data  (RFIFO_out),
		.wr_count (RFIFO_wr_count),
		.rd_count (RFIFO_rd_count)
	);

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_receiver_centre -f receiver_centre.f

./obj_dir/Vtb_receiver_centre | tee sim.log

if grep -qx "TEST RESULT: PASS" sim.log; then
	echo "Simulation finished without errors"
else
	echo "Simulation reported errors" >&2
	exit 1
fi

// File: rx_byte_if.sv
`timescale 1ns/1ps
`include "rc_consts.svh"

interface rx_byte_if;

	logic [`RC_DATA_W-1:0] data;
	logic                  valid;
	logic                  frame_err;
	logic                  busy;

	modport rx (
		output data,
		output valid,
		output frame_err,
		output busy
	);

	modport ctrl (
		input data,
		input valid,
		input frame_err,
		input busy
	);

endinterface

// File: rx_fifo.sv
`timescale 1ns/1ps
`include "rc_consts.svh"

module rx_fifo (
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic                    wr_en,
	input  logic [`RC_DATA_W-1:0]   wr_data,
	input  logic                    rd_en,
	output logic [`RC_WORD_W-1:0]   rd_data,
	output logic [`RC_WR_CNT_W-1:0] wr_count,
	output logic [`RC_RD_CNT_W-1:0] rd_count
);

	logic [`RC_WORD_W-1:0]   mem [0:`RC_FIFO_WORDS-1];
	logic [`RC_RD_CNT_W-2:0] wr_ptr;
	logic [`RC_RD_CNT_W-2:0] rd_ptr;
	logic [`RC_DATA_W-1:0]   hi_byte;
	logic                    half;
	logic                    full;
	logic                    accept;
	logic                    push;
	logic                    pop;

	assign full   = (rd_count == `RC_RD_CNT_W'(`RC_FIFO_WORDS));
	assign accept = wr_en && !full;
	// A word is pushed when the second byte of a pair arrives
	assign push   = accept && half;
	assign pop    = rd_en && (rd_count != '0);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			half     <= 1'b0;
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			rd_count <= '0;
		end else begin
			if (accept)
				half <= !half;
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   rd_count <= rd_count + 1'b1;
				2'b01:   rd_count <= rd_count - 1'b1;
				default: rd_count <= rd_count;
			endcase
		end
	end

	// First byte of a pair lands in the upper half of the word
	always_ff @(posedge clock) begin
		if (accept && !half)
			hi_byte <= wr_data;
		if (push)
			mem[wr_ptr] <= {hi_byte, wr_data};
	end

	assign rd_data  = mem[rd_ptr];
	assign wr_count = {rd_count, half};

endmodule

// File: tb_receiver_centre.sv
`timescale 1ns/1ps
`include "rc_consts.svh"

module tb_receiver_centre;

	localparam int bit_period   = 16;
	localparam int timeout_bits = 12;
	localparam int frame_limit  = 400;

	logic                    clock;
	logic                    rst_n;
	logic [`RC_TIMER_W-1:0]  uart_cpd;
	logic [`RC_TIMER_W-1:0]  uart_timer_cap;
	logic                    fpga_rxd;
	logic                    want_at;
	logic                    at_response_flag;
	logic                    rfifo_rd_en;
	logic [`RC_WORD_W-1:0]   rfifo_out;
	logic [`RC_WR_CNT_W-1:0] rfifo_wr_count;
	logic [`RC_RD_CNT_W-1:0] rfifo_rd_count;
	logic [`RC_DATA_W-1:0]   stream_select;
	logic                    ds_sending_flag;
	logic                    tx_start;
	logic [`RC_DATA_W-1:0]   tx_data;
	logic                    tx_done;
	logic [`RC_DATA_W-1:0]   last_id;
	int                      errors;
	int                      tests_run;
	int                      tests_failed;
	int                      test_errors_at_start;

	receiver_centre dut (
		.clock            (clock),
		.rst_n            (rst_n),
		.uart_cpd         (uart_cpd),
		.uart_timer_cap   (uart_timer_cap),
		.fpga_rxd         (fpga_rxd),
		.want_at          (want_at),
		.at_response_flag (at_response_flag),
		.RFIFO_rd_en      (rfifo_rd_en),
		.RFIFO_out        (rfifo_out),
		.RFIFO_wr_count   (rfifo_wr_count),
		.RFIFO_rd_count   (rfifo_rd_count),
		.stream_select    (stream_select),
		.ds_sending_flag  (ds_sending_flag)
	);

	tb_uart_tx u_tx (
		.clock (clock),
		.rst_n (rst_n),
		.cpd   (uart_cpd),
		.start (tx_start),
		.data  (tx_data),
		.txd   (fpga_rxd),
		.done  (tx_done)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// Inputs change and outputs are sampled 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) next_cycle();
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got == exp) else begin
			$display("MISMATCH time=%0t signal=%s got=0x%0h expected=0x%0h",
				$time, name, got, exp);
			errors++;
		end
	endtask

	task automatic send_byte(input logic [`RC_DATA_W-1:0] b);
		int n;
		n = 0;
		tx_data  = b;
		tx_start = 1'b1;
		next_cycle();
		tx_start = 1'b0;
		while (!tx_done && n < frame_limit) begin
			next_cycle();
			n++;
		end
		assert (tx_done) else begin
			$display("Timeout at %0t: the serial frame for byte 0x%0h never completed",
				$time, b);
			errors++;
		end
	endtask

	// Checks the word on the show-ahead output, then pops it
	task automatic read_word(input logic [`RC_WORD_W-1:0] exp);
		check_value("RFIFO_out", 32'(rfifo_out), 32'(exp));
		rfifo_rd_en = 1'b1;
		next_cycle();
		rfifo_rd_en = 1'b0;
	endtask

	task automatic start_test();
		test_errors_at_start = errors;
		tests_run++;
	endtask

	task automatic finish_test(input string name);
		if (errors == test_errors_at_start) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, errors - test_errors_at_start);
			tests_failed++;
		end
	endtask

	task automatic test_reset_state();
		start_test();
		check_value("stream_select", 32'(stream_select), 32'h0);
		check_value("ds_sending_flag", 32'(ds_sending_flag), 32'h0);
		check_value("at_response_flag", 32'(at_response_flag), 32'h0);
		check_value("RFIFO_wr_count", 32'(rfifo_wr_count), 32'h0);
		check_value("RFIFO_rd_count", 32'(rfifo_rd_count), 32'h0);
		finish_test("reset_state");
	endtask

	task automatic test_at_response();
		start_test();
		want_at = 1'b1;
		idle_cycles(2);
		send_byte("O");
		send_byte("K");
		check_value("at_response_flag", 32'(at_response_flag), 32'h1);
		check_value("RFIFO_rd_count", 32'(rfifo_rd_count), 32'h1);
		check_value("RFIFO_wr_count", 32'(rfifo_wr_count), 32'h2);
		read_word(16'h4F4B);
		check_value("RFIFO_wr_count", 32'(rfifo_wr_count), 32'h0);
		check_value("RFIFO_rd_count", 32'(rfifo_rd_count), 32'h0);
		want_at = 1'b0;
		next_cycle();
		check_value("at_response_flag", 32'(at_response_flag), 32'h0);
		finish_test("at_response");
	endtask

	task automatic test_at_packing();
		logic [`RC_DATA_W-1:0] bytes [6];
		start_test();
		want_at = 1'b1;
		idle_cycles(2);
		for (int i = 0; i < 6; i++) begin
			bytes[i] = 8'($urandom());
			// Keep 'O' and 'K' out so the flag cannot rise by chance
			if (bytes[i] == "O" || bytes[i] == "K")
				bytes[i] = bytes[i] ^ 8'h20;
			send_byte(bytes[i]);
		end
		check_value("RFIFO_wr_count", 32'(rfifo_wr_count), 32'd6);
		check_value("RFIFO_rd_count", 32'(rfifo_rd_count), 32'd3);
		for (int i = 0; i < 3; i++)
			read_word({bytes[2*i], bytes[2*i+1]});
		check_value("RFIFO_rd_count", 32'(rfifo_rd_count), 32'd0);
		send_byte("K");
		check_value("at_response_flag", 32'(at_response_flag), 32'h0);
		check_value("RFIFO_wr_count", 32'(rfifo_wr_count), 32'd1);
		finish_test("at_packing");
	endtask

	task automatic test_command_decoding();
		logic [`RC_DATA_W-1:0] id;
		start_test();
		want_at = 1'b0;
		idle_cycles(2);
		send_byte(8'h00);
		send_byte(8'h78);
		send_byte(8'h01);
		check_value("stream_select", 32'(stream_select), 32'h01);
		send_byte(8'h79);
		send_byte(8'h01);
		check_value("ds_sending_flag", 32'(ds_sending_flag), 32'h1);
		id = 8'($urandom());
		// The id has to differ from the current 1 and from the 3 and 5 of the timeout test
		if (id == 8'h01 || id == 8'h03 || id == 8'h05)
			id = id ^ 8'h80;
		send_byte(8'h78);
		send_byte(id);
		check_value("stream_select", 32'(stream_select), 32'(id));
		last_id = id;
		finish_test("command_decoding");
	endtask

	task automatic test_operand_timeout();
		start_test();
		send_byte(8'h78);
		idle_cycles(bit_period * timeout_bits + 32);
		send_byte(8'h05);
		check_value("stream_select", 32'(stream_select), 32'(last_id));
		send_byte(8'h78);
		send_byte(8'h03);
		check_value("stream_select", 32'(stream_select), 32'h03);
		finish_test("operand_timeout");
	endtask

	initial begin
		errors         = 0;
		tests_run      = 0;
		tests_failed   = 0;
		last_id        = '0;
		rst_n          = 1'b0;
		uart_cpd       = `RC_TIMER_W'(bit_period);
		uart_timer_cap = `RC_TIMER_W'(timeout_bits);
		want_at        = 1'b0;
		rfifo_rd_en    = 1'b0;
		tx_start       = 1'b0;
		tx_data        = '0;
		void'($urandom(32'h4607));
		repeat (2) @(posedge clock);
		#1;
		rst_n = 1'b1;
		next_cycle();

		test_reset_state();
		test_at_response();
		test_at_packing();
		test_command_decoding();
		test_operand_timeout();

		$display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: tb_uart_tx.sv
`timescale 1ns/1ps
`include "rc_consts.svh"

// Serial line model that sends one 8N1 frame for each start pulse
module tb_uart_tx (
	input  logic                   clock,
	input  logic                   rst_n,
	input  logic [`RC_TIMER_W-1:0] cpd,
	input  logic                   start,
	input  logic [`RC_DATA_W-1:0]  data,
	output logic                   txd,
	output logic                   done
);

	logic                   active;
	logic                   line_q;
	logic [9:0]             frame;
	logic [3:0]             bit_idx;
	logic [`RC_TIMER_W-1:0] cnt;

	// The line reads as idle while reset is held
	assign txd = line_q | !rst_n;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			active  <= 1'b0;
			line_q  <= 1'b1;
			done    <= 1'b0;
			cnt     <= '0;
			bit_idx <= '0;
			frame   <= '1;
		end else begin
			done <= 1'b0;
			if (!active) begin
				if (start) begin
					// Stop bit on top, data LSB first, start bit at the bottom
					frame   <= {1'b1, data, 1'b0};
					line_q  <= 1'b0;
					active  <= 1'b1;
					cnt     <= '0;
					bit_idx <= '0;
				end
			end else if (cnt == cpd - 1'b1) begin
				cnt <= '0;
				if (bit_idx == 4'd9) begin
					active <= 1'b0;
					line_q <= 1'b1;
					done   <= 1'b1;
				end else begin
					bit_idx <= bit_idx + 1'b1;
					line_q  <= frame[bit_idx + 1'b1];
				end
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

// File: uart_rx.sv
`timescale 1ns/1ps
`include "rc_consts.svh"

module uart_rx (
	input  logic                   clock,
	input  logic                   rst_n,
	input  logic [`RC_TIMER_W-1:0] cpd,
	input  logic                   rxd,
	rx_byte_if.rx                  rxb
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_START,
		S_DATA,
		S_STOP
	} rx_state_t;

	rx_state_t              state;
	logic                   rxd_meta;
	logic                   rxd_sync;
	logic                   rxd_prev;
	logic [`RC_TIMER_W-1:0] cnt;
	logic [2:0]             bit_idx;
	logic [`RC_DATA_W-1:0]  shreg;
	logic                   bit_tick;

	// Line idles high, so the synchronizer resets to one
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	assign bit_tick = (cnt == cpd - 1'b1);
	assign rxb.busy = (state != S_IDLE);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state     <= S_IDLE;
			cnt       <= '0;
			bit_idx   <= '0;
			rxb.valid <= 1'b0;
		end else begin
			rxb.valid <= 1'b0;
			case (state)
				S_IDLE: begin
					cnt <= '0;
					if (rxd_prev && !rxd_sync)
						state <= S_START;
				end
				// Half a bit in, the line must still be low or the start was a glitch
				S_START: begin
					if (cnt == (cpd >> 1)) begin
						cnt     <= '0;
						bit_idx <= '0;
						state   <= rxd_sync ? S_IDLE : S_DATA;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				S_DATA: begin
					if (bit_tick) begin
						cnt     <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= S_STOP;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				S_STOP: begin
					if (bit_tick) begin
						cnt       <= '0;
						rxb.valid <= 1'b1;
						state     <= S_IDLE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge clock) begin
		if (state == S_DATA && bit_tick)
			shreg <= {rxd_sync, shreg[`RC_DATA_W-1:1]};
		if (state == S_STOP && bit_tick) begin
			rxb.data      <= shreg;
			rxb.frame_err <= !rxd_sync;
		end
	end

endmodule
